// File: common/llink_cfg.svh
// Link geometry, flit field widths and userbit positions
`ifndef LLINK_CFG_SVH
`define LLINK_CFG_SVH

// PHY lane bundle
`define LLINK_LANES    4
`define LLINK_LANE_W   40

// Flit fields
`define LLINK_DATA_W   128
`define LLINK_CRC_W    16

// Reserved userbits inside the lane bundle
`define LLINK_STB_LANE 0
`define LLINK_STB_BIT  1
`define LLINK_MRK_LANE 0
`define LLINK_MRK_BIT  39

// Alignment delay inputs
`define LLINK_DELAY_W  16

`endif

// File: common/llink_pkg.sv
// Flit struct, lane bundle type and userbit struct for the logic link
`default_nettype none

`include "llink_cfg.svh"

package llink_pkg;

  //////////////////////////////////////////////////////////////////////
  // One link word, first field lands in the top bits
  typedef struct packed {
    logic [3:0]               state;
    logic [1:0]               protid;
    logic [`LLINK_DATA_W-1:0] data;
    logic                     dvalid;
    logic [`LLINK_CRC_W-1:0]  crc;
    logic                     crc_valid;
    logic                     valid;
  } llink_flit_t;

  //////////////////////////////////////////////////////////////////////
  // Lanes on the PHY side
  // Flit bits fill from lane 0 bit 0 upward around the userbit slots
  typedef logic [`LLINK_LANES-1:0][`LLINK_LANE_W-1:0] llink_lanes_t;

  // Sideband bits carried in the reserved lane positions
  typedef struct packed {
    logic marker;
    logic strobe;
  } userbits_t;

endpackage

`default_nettype wire

// File: auto_sync/ll_auto_sync.sv
// Online delay counters, marker and strobe generator, transmit strobe counter
`default_nettype none

`include "llink_cfg.svh"

module ll_auto_sync
  import llink_pkg::*;
(
  input  logic                      clk_wr,
  input  logic                      rst_n,
  input  logic                      tx_online,
  input  logic                      rx_online,
  input  logic [`LLINK_DELAY_W-1:0] delay_x_value,
  input  logic [`LLINK_DELAY_W-1:0] delay_y_value,
  input  logic [`LLINK_DELAY_W-1:0] delay_z_value,
  output logic                      tx_online_delay,
  output logic                      rx_online_delay,
  output userbits_t                 tx_userbits,
  output logic [31:0]               tx_debug_status
);

  localparam int DW = `LLINK_DELAY_W;

  //////////////////////////////////////////////////////////////////////
  // Online delay
  // Index 0 is the receive side, index 1 the transmit side
  logic [1:0]          online_raw;
  logic [1:0][DW-1:0]  delay_cfg;
  logic                online_level [2];

  assign online_raw = {tx_online, rx_online};
  assign delay_cfg  = {delay_y_value, delay_x_value};

  for (genvar ch = 0; ch < 2; ch++) begin : g_delay
    logic [DW-1:0] target;
    logic [DW-1:0] edge_cnt;

    // Zero still costs one edge
    assign target = (delay_cfg[ch] == '0) ? DW'(1) : delay_cfg[ch];

    always_ff @(posedge clk_wr or negedge rst_n) begin
      if (!rst_n) begin
        edge_cnt         <= '0;
        online_level[ch] <= 1'b0;
      end else if (!online_raw[ch]) begin
        edge_cnt         <= '0;
        online_level[ch] <= 1'b0;
      end else begin
        // Saturates once the target edge is reached
        if (edge_cnt != target) begin
          edge_cnt <= edge_cnt + 1'b1;
        end
        if (edge_cnt == target - 1'b1) begin
          online_level[ch] <= 1'b1;
        end
      end
    end
  end

  assign rx_online_delay = online_level[0];
  assign tx_online_delay = online_level[1];

  //////////////////////////////////////////////////////////////////////
  // Marker and strobe
  logic [DW-1:0] period;
  logic [DW-1:0] word_cnt;
  logic          phase_q;
  logic          stb_sent_q;

  assign period = (delay_z_value == '0) ? DW'(1) : delay_z_value;

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      word_cnt <= '0;
      phase_q  <= 1'b0;
    end else if (!tx_online_delay) begin
      word_cnt <= '0;
      phase_q  <= 1'b0;
    end else begin
      // Wrap also covers a period shortened while online
      word_cnt <= (word_cnt >= period - 1'b1) ? '0 : word_cnt + 1'b1;
      phase_q  <= ~phase_q;
    end
  end

  assign tx_userbits.marker = tx_online_delay & ~phase_q;
  assign tx_userbits.strobe = tx_online_delay & (word_cnt == '0);

  // Counted as the strobe word leaves on tx_phy
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      stb_sent_q      <= 1'b0;
      tx_debug_status <= '0;
    end else begin
      stb_sent_q <= tx_userbits.strobe;
      if (stb_sent_q) begin
        tx_debug_status <= tx_debug_status + 32'd1;
      end
    end
  end

endmodule

`default_nettype wire

// File: phy_if/tx_lane_pack.sv
// Transmit lane packer with userbit insertion and output register
`default_nettype none

`include "llink_cfg.svh"

module tx_lane_pack
  import llink_pkg::*;
(
  input  logic         clk_wr,
  input  logic         rst_n,
  input  logic         tx_online_delay,
  input  llink_flit_t  ustrm,
  input  userbits_t    tx_userbits,
  output llink_lanes_t tx_phy
);

  localparam int FLIT_W  = $bits(llink_flit_t);
  localparam int FLAT_W  = $bits(llink_lanes_t);
  localparam int STB_POS = `LLINK_STB_LANE * `LLINK_LANE_W + `LLINK_STB_BIT;
  localparam int MRK_POS = `LLINK_MRK_LANE * `LLINK_LANE_W + `LLINK_MRK_BIT;

  // Flit bit for lane position p sits below p by the userbit slots skipped
  function automatic llink_lanes_t pack_lanes(input llink_flit_t flit,
                                              input userbits_t   ub);
    logic [FLAT_W-1:0] flat;
    logic [FLIT_W-1:0] bits;
    int                idx;
    flat = '0;
    bits = flit;
    for (int p = 0; p < FLAT_W; p++) begin
      idx = p - ((p > STB_POS) ? 1 : 0) - ((p > MRK_POS) ? 1 : 0);
      if (p == STB_POS) begin
        flat[p] = ub.strobe;
      end else if (p == MRK_POS) begin
        flat[p] = ub.marker;
      end else if (idx < FLIT_W) begin
        flat[p] = bits[idx];
      end
    end
    return llink_lanes_t'(flat);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Output register, quiet while offline
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      tx_phy <= '0;
    end else if (tx_online_delay) begin
      tx_phy <= pack_lanes(ustrm, tx_userbits);
    end else begin
      tx_phy <= '0;
    end
  end

endmodule

`default_nettype wire

// File: phy_if/rx_lane_unpack.sv
// Receive lane register and unpacker into flit and userbits
`default_nettype none

`include "llink_cfg.svh"

module rx_lane_unpack
  import llink_pkg::*;
(
  input  logic         clk_wr,
  input  logic         rst_n,
  input  llink_lanes_t rx_phy,
  output llink_flit_t  rx_flit,
  output userbits_t    rx_userbits
);

  localparam int FLIT_W  = $bits(llink_flit_t);
  localparam int FLAT_W  = $bits(llink_lanes_t);
  localparam int STB_POS = `LLINK_STB_LANE * `LLINK_LANE_W + `LLINK_STB_BIT;
  localparam int MRK_POS = `LLINK_MRK_LANE * `LLINK_LANE_W + `LLINK_MRK_BIT;

  // Inverse of the transmit packing, spare lane bits dropped
  function automatic llink_flit_t unpack_flit(input llink_lanes_t lanes);
    logic [FLAT_W-1:0] flat;
    logic [FLIT_W-1:0] bits;
    int                idx;
    flat = lanes;
    bits = '0;
    for (int p = 0; p < FLAT_W; p++) begin
      idx = p - ((p > STB_POS) ? 1 : 0) - ((p > MRK_POS) ? 1 : 0);
      if (p != STB_POS && p != MRK_POS && idx < FLIT_W) begin
        bits[idx] = flat[p];
      end
    end
    return llink_flit_t'(bits);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Input register
  llink_lanes_t lanes_q;

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      lanes_q <= '0;
    end else begin
      lanes_q <= rx_phy;
    end
  end

  assign rx_flit            = unpack_flit(lanes_q);
  assign rx_userbits.marker = lanes_q[`LLINK_MRK_LANE][`LLINK_MRK_BIT];
  assign rx_userbits.strobe = lanes_q[`LLINK_STB_LANE][`LLINK_STB_BIT];

endmodule

`default_nettype wire

// File: source/dstrm_name_map.sv
// Downstream flit gating and receive strobe counter
`default_nettype none

module dstrm_name_map
  import llink_pkg::*;
(
  input  logic        clk_wr,
  input  logic        rst_n,
  input  logic        rx_online_delay,
  input  llink_flit_t rx_flit,
  input  userbits_t   rx_userbits,
  output llink_flit_t dstrm,
  output logic [31:0] rx_debug_status
);

  // Nothing leaks downstream before alignment
  assign dstrm = rx_online_delay ? rx_flit : '0;

  //////////////////////////////////////////////////////////////////////
  // Received strobes, held while offline
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      rx_debug_status <= '0;
    end else if (rx_online_delay && rx_userbits.strobe) begin
      rx_debug_status <= rx_debug_status + 32'd1;
    end
  end

endmodule

`default_nettype wire

// File: source/llink_top.sv
// Logic link endpoint top with auto sync, lane packing, unpacking and name map
`default_nettype none

`include "llink_cfg.svh"

module llink_top
  import llink_pkg::*;
(
  input  logic                      clk_wr,
  input  logic                      rst_n,

  // Control
  input  logic                      tx_online,
  input  logic                      rx_online,

  // PHY side
  output llink_lanes_t              tx_phy,
  input  llink_lanes_t              rx_phy,

  // User side
  input  llink_flit_t               ustrm,
  output llink_flit_t               dstrm,

  // Debug
  output logic [31:0]               tx_debug_status,
  output logic [31:0]               rx_debug_status,

  // Alignment delays
  input  logic [`LLINK_DELAY_W-1:0] delay_x_value,
  input  logic [`LLINK_DELAY_W-1:0] delay_y_value,
  input  logic [`LLINK_DELAY_W-1:0] delay_z_value
);

  //////////////////////////////////////////////////////////////////////
  // Interconnect
  logic        tx_online_delay;
  logic        rx_online_delay;
  userbits_t   tx_userbits;
  userbits_t   rx_userbits;
  llink_flit_t rx_flit;

  //////////////////////////////////////////////////////////////////////
  // Auto sync
  ll_auto_sync ll_auto_sync_i (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_x_value   (delay_x_value),
    .delay_y_value   (delay_y_value),
    .delay_z_value   (delay_z_value),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .tx_userbits     (tx_userbits),
    .tx_debug_status (tx_debug_status)
  );

  //////////////////////////////////////////////////////////////////////
  // PHY interface
  tx_lane_pack tx_lane_pack_i (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .tx_online_delay (tx_online_delay),
    .ustrm           (ustrm),
    .tx_userbits     (tx_userbits),
    .tx_phy          (tx_phy)
  );

  rx_lane_unpack rx_lane_unpack_i (
    .clk_wr      (clk_wr),
    .rst_n       (rst_n),
    .rx_phy      (rx_phy),
    .rx_flit     (rx_flit),
    .rx_userbits (rx_userbits)
  );

  //////////////////////////////////////////////////////////////////////
  // User interface
  dstrm_name_map dstrm_name_map_i (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .rx_online_delay (rx_online_delay),
    .rx_flit         (rx_flit),
    .rx_userbits     (rx_userbits),
    .dstrm           (dstrm),
    .rx_debug_status (rx_debug_status)
  );

endmodule

`default_nettype wire

// File: tb/tb_llink_top.sv
// Loopback testbench for llink_top with reference model and concurrent assertions
`default_nettype none

`include "llink_cfg.svh"

module tb_llink_top
  import llink_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  logic                      clk_wr;
  logic                      rst_n;
  logic                      tx_online;
  logic                      rx_online;
  logic [`LLINK_DELAY_W-1:0] delay_x_value;
  logic [`LLINK_DELAY_W-1:0] delay_y_value;
  logic [`LLINK_DELAY_W-1:0] delay_z_value;
  llink_flit_t               ustrm;
  llink_flit_t               dstrm;
  llink_lanes_t              tx_phy;
  logic [31:0]               tx_debug_status;
  logic [31:0]               rx_debug_status;

  int errors   = 0;
  int timeouts = 0;

  // PHY lanes looped straight back
  llink_top llink_top_inst (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .tx_phy          (tx_phy),
    .rx_phy          (tx_phy),
    .ustrm           (ustrm),
    .dstrm           (dstrm),
    .tx_debug_status (tx_debug_status),
    .rx_debug_status (rx_debug_status),
    .delay_x_value   (delay_x_value),
    .delay_y_value   (delay_y_value),
    .delay_z_value   (delay_z_value)
  );

  initial begin
    clk_wr = 1'b0;
    forever #20 clk_wr = ~clk_wr;
  end

  ////////////////////////////////////////////////////////////////////////
  // Reference model
  // One word on the wire as the model sees it
  typedef struct packed {
    logic        mrk;
    logic        stb;
    llink_flit_t flit;
  } wire_word_t;

  wire_word_t  pipe_q[$];
  wire_word_t  exp_sent;
  wire_word_t  exp_recv;
  llink_flit_t exp_dstrm;
  logic        exp_tx_on;
  logic        exp_rx_on;
  logic [31:0] exp_tx_cnt;
  logic [31:0] exp_rx_cnt;
  int          tx_edges;
  int          rx_edges;
  int          word_idx;

  function automatic int at_least_one(input logic [`LLINK_DELAY_W-1:0] value);
    return (value == '0) ? 1 : int'(value);
  endfunction

  // Strobe slot at bit 1, marker slot at bit 39, five spare bits on top
  function automatic llink_lanes_t expected_lanes(input wire_word_t word);
    logic [$bits(llink_flit_t)-1:0] bits;
    bits = word.flit;
    return {5'b0, bits[152:38], word.mrk, bits[37:1], word.stb, bits[0]};
  endfunction

  always @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      pipe_q.delete();
      pipe_q.push_back('0);
      exp_sent   = '0;
      exp_recv   = '0;
      exp_dstrm  = '0;
      exp_tx_on  = 1'b0;
      exp_rx_on  = 1'b0;
      exp_tx_cnt = '0;
      exp_rx_cnt = '0;
      tx_edges   = 0;
      rx_edges   = 0;
      word_idx   = 0;
    end else begin
      // Counters see the words present before this edge
      if (exp_rx_on && exp_recv.stb) begin
        exp_rx_cnt = exp_rx_cnt + 32'd1;
      end
      exp_tx_cnt = exp_tx_cnt + exp_sent.stb;
      exp_recv   = pipe_q.pop_front();
      if (exp_tx_on) begin
        exp_sent.mrk  = (word_idx % 2) == 0;
        exp_sent.stb  = (word_idx % at_least_one(delay_z_value)) == 0;
        exp_sent.flit = ustrm;
        word_idx++;
      end else begin
        exp_sent = '0;
        word_idx = 0;
      end
      pipe_q.push_back(exp_sent);
      tx_edges  = tx_online ? tx_edges + 1 : 0;
      rx_edges  = rx_online ? rx_edges + 1 : 0;
      exp_tx_on = tx_edges >= at_least_one(delay_y_value);
      exp_rx_on = rx_edges >= at_least_one(delay_x_value);
      exp_dstrm = exp_rx_on ? exp_recv.flit : '0;
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // Checks
  task automatic log_mismatch(input string name, input logic [159:0] expected,
                              input logic [159:0] actual);
    errors++;
    $display("ERROR %s expected %h actual %h", name, expected, actual);
  endtask

  a_tx_phy: assert property (@(posedge clk_wr) disable iff (!rst_n)
    tx_phy == expected_lanes(exp_sent))
    else log_mismatch("tx_phy", expected_lanes($sampled(exp_sent)), $sampled(tx_phy));

  a_userbits: assert property (@(posedge clk_wr) disable iff (!rst_n)
    {tx_phy[`LLINK_MRK_LANE][`LLINK_MRK_BIT], tx_phy[`LLINK_STB_LANE][`LLINK_STB_BIT]}
      == {exp_sent.mrk, exp_sent.stb})
    else log_mismatch("userbits", {$sampled(exp_sent.mrk), $sampled(exp_sent.stb)},
                      {$sampled(tx_phy[`LLINK_MRK_LANE][`LLINK_MRK_BIT]),
                       $sampled(tx_phy[`LLINK_STB_LANE][`LLINK_STB_BIT])});

  a_dstrm: assert property (@(posedge clk_wr) disable iff (!rst_n) dstrm == exp_dstrm)
    else log_mismatch("dstrm", $sampled(exp_dstrm), $sampled(dstrm));

  a_tx_count: assert property (@(posedge clk_wr) disable iff (!rst_n)
    tx_debug_status == exp_tx_cnt)
    else log_mismatch("tx_debug_status", $sampled(exp_tx_cnt), $sampled(tx_debug_status));

  a_rx_count: assert property (@(posedge clk_wr) disable iff (!rst_n)
    rx_debug_status == exp_rx_cnt)
    else log_mismatch("rx_debug_status", $sampled(exp_rx_cnt), $sampled(rx_debug_status));

  ////////////////////////////////////////////////////////////////////////
  // Stimulus
  task automatic send_words(input int count);
    logic [159:0] rnd;
    repeat (count) begin
      @(posedge clk_wr);
      #2;
      rnd   = {$urandom, $urandom, $urandom, $urandom, $urandom};
      ustrm = rnd[$bits(llink_flit_t)-1:0];
    end
  endtask

  initial begin
    int polls;
    void'($urandom(73697));
    rst_n         = 1'b0;
    tx_online     = 1'b0;
    rx_online     = 1'b0;
    ustrm         = '0;
    delay_x_value = 16'd5;
    delay_y_value = 16'd3;
    delay_z_value = 16'd4;
    repeat (3) @(posedge clk_wr);
    #2;
    rst_n = 1'b1;

    // Offline words must not leak
    send_words(6);
    tx_online = 1'b1;
    rx_online = 1'b1;

    polls = 0;
    while (tx_phy == '0 && polls < 20) begin
      send_words(1);
      polls++;
    end
    if (tx_phy == '0) begin
      $display("Timeout: tx_phy stayed zero after tx_online was raised");
      timeouts++;
    end

    polls = 0;
    while (dstrm == '0 && polls < 20) begin
      send_words(1);
      polls++;
    end
    if (dstrm == '0) begin
      $display("Timeout: dstrm stayed zero after rx_online was raised");
      timeouts++;
    end

    send_words(200);

    // Receive side drops while transmit keeps going
    rx_online = 1'b0;
    send_words(20);
    tx_online = 1'b0;
    send_words(6);

    $display("Summary: %0d errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
+incdir+common
common/llink_pkg.sv
auto_sync/ll_auto_sync.sv
phy_if/tx_lane_pack.sv
phy_if/rx_lane_unpack.sv
source/dstrm_name_map.sv
source/llink_top.sv
tb/tb_llink_top.sv

// File: Bender.yml
package:
  name: llink

export_include_dirs:
  - common

sources:
  - files:
      - common/llink_pkg.sv
      - auto_sync/ll_auto_sync.sv
      - phy_if/tx_lane_pack.sv
      - phy_if/rx_lane_unpack.sv
      - source/dstrm_name_map.sv
      - source/llink_top.sv
  - target: simulation
    files:
      - tb/tb_llink_top.sv
